//--- verilog/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// integer register width
`define EXU_XLEN 64

// multiplier bits retired per iteration
// must divide EXU_XLEN evenly
`define EXU_MUL_BITS 2

`endif

//--- verilog/exu_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

    localparam int unsigned XLEN = `EXU_XLEN;

    // pc, register, csr and immediate values all share this word
    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [4:0] {
        add    = 5'd0,
        sub    = 5'd1,
        ret_a  = 5'd2,
        ret_b  = 5'd3,
        xor_op = 5'd4,
        or_op  = 5'd5,
        and_op = 5'd6,
        sll    = 5'd7,
        srl    = 5'd8,
        sra    = 5'd9,
        slt    = 5'd10,
        sltu   = 5'd11,
        eq     = 5'd12,
        ge     = 5'd13,
        geu    = 5'd14,
        // long operations, served by the iterative units
        mul    = 5'd15,
        div    = 5'd16,
        divu   = 5'd17,
        rem    = 5'd18,
        remu   = 5'd19
    } alu_op_e;

    // operand a source, unlisted codes fall back to pc
    typedef enum logic [1:0] {
        opa_pc  = 2'd0,
        opa_rs1 = 2'd1
    } opa_sel_e;

    // operand b source, unlisted codes fall back to imm
    typedef enum logic [1:0] {
        opb_imm = 2'd0,
        opb_rs2 = 2'd1,
        opb_csr = 2'd2
    } opb_sel_e;

endpackage

`default_nettype wire

//--- verilog/muldiv_if.sv
`default_nettype none

interface muldiv_if;
    import exu_pkg::*;

    // request side, driven by the ALU
    logic  start;
    logic  abort;
    xlen_t a;
    xlen_t b;
    logic  is_signed;
    logic  want_rem;

    // response side, driven by the iterative unit
    logic  done;
    xlen_t result;

    modport requester (
        output start, abort, a, b, is_signed, want_rem,
        input  done, result
    );

    modport unit (
        input  start, abort, a, b, is_signed, want_rem,
        output done, result
    );

endinterface

`default_nettype wire

//--- verilog/exu_alu.sv
`default_nettype none

module exu_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              issue,
    input  exu_pkg::alu_op_e  operate,
    input  exu_pkg::opa_sel_e sel_a,
    input  exu_pkg::opb_sel_e sel_b,
    input  logic              rs1to32,
    input  exu_pkg::xlen_t    pc,
    input  exu_pkg::xlen_t    rs1,
    input  exu_pkg::xlen_t    rs2,
    input  exu_pkg::xlen_t    csr,
    input  exu_pkg::xlen_t    imm,
    output exu_pkg::xlen_t    res,
    output logic              alu_wait,
    muldiv_if.requester       mul_port,
    muldiv_if.requester       div_port
);
    import exu_pkg::*;

    xlen_t      rs1_val;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      single_res;
    logic [5:0] shamt;
    logic       is_mul;
    logic       is_div;
    logic       accept;
    logic       wait_mul;

    // word ops see rs1 zero-extended from 32 bits
    assign rs1_val = rs1to32 ? {32'b0, rs1[31:0]} : rs1;
    assign op_a    = (sel_a == opa_rs1) ? rs1_val : pc;

    always_comb begin
        case (sel_b)
            opb_rs2: op_b = rs2;
            opb_csr: op_b = csr;
            default: op_b = imm;
        endcase
    end

    assign shamt = op_b[5:0];

    always_comb begin
        case (operate)
            add:     single_res = op_a + op_b;
            sub:     single_res = op_a - op_b;
            ret_a:   single_res = op_a;
            ret_b:   single_res = op_b;
            xor_op:  single_res = op_a ^ op_b;
            or_op:   single_res = op_a | op_b;
            and_op:  single_res = op_a & op_b;
            sll:     single_res = op_a << shamt;
            srl:     single_res = op_a >> shamt;
            sra: begin
                if (rs1to32) begin
                    single_res = {32'b0, $signed(op_a[31:0]) >>> shamt};
                end else begin
                    single_res = $signed(op_a) >>> shamt;
                end
            end
            slt:     single_res = xlen_t'($signed(op_a) < $signed(op_b));
            sltu:    single_res = xlen_t'(op_a < op_b);
            eq:      single_res = xlen_t'(op_a == op_b);
            ge:      single_res = xlen_t'($signed(op_a) >= $signed(op_b));
            geu:     single_res = xlen_t'(op_a >= op_b);
            default: single_res = '0;
        endcase
    end

    assign is_mul = (operate == mul);
    assign is_div = (operate inside {div, divu, rem, remu});
    assign accept = issue && !alu_wait;

    // a long op is not launched into a flush, the unit would abort it anyway
    assign mul_port.start     = accept && is_mul && !flush;
    assign mul_port.abort     = flush;
    assign mul_port.a         = op_a;
    assign mul_port.b         = op_b;
    assign mul_port.is_signed = 1'b0;
    assign mul_port.want_rem  = 1'b0;

    assign div_port.start     = accept && is_div && !flush;
    assign div_port.abort     = flush;
    assign div_port.a         = op_a;
    assign div_port.b         = op_b;
    assign div_port.is_signed = (operate inside {div, rem});
    assign div_port.want_rem  = (operate inside {rem, remu});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res      <= '0;
            alu_wait <= 1'b0;
            wait_mul <= 1'b0;
        end else if (alu_wait) begin
            if (flush) begin
                alu_wait <= 1'b0;
            end else if (wait_mul && mul_port.done) begin
                res      <= mul_port.result;
                alu_wait <= 1'b0;
            end else if (!wait_mul && div_port.done) begin
                res      <= div_port.result;
                alu_wait <= 1'b0;
            end
        end else if (issue) begin
            if (is_mul || is_div) begin
                if (!flush) begin
                    alu_wait <= 1'b1;
                    wait_mul <= is_mul;
                end
            end else begin
                res <= single_res;
            end
        end
    end

    // divider is the slowest unit, 64 steps plus the result edge
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(alu_wait) |-> ##[1:65] !alu_wait);

    assert property (@(posedge clk) disable iff (!rst_n)
        mul_port.done |-> alu_wait && wait_mul);

    assert property (@(posedge clk) disable iff (!rst_n)
        div_port.done |-> alu_wait && !wait_mul);

endmodule

`default_nettype wire

//--- verilog/exu_multiplier.sv
`default_nettype none

`include "exu_settings.svh"

module exu_multiplier #(
    parameter int unsigned BITS_PER_CYCLE = `EXU_MUL_BITS
) (
    input  logic   clk,
    input  logic   rst_n,
    muldiv_if.unit port
);
    import exu_pkg::*;

    localparam int unsigned ITERS = XLEN / BITS_PER_CYCLE;
    localparam int unsigned CNT_W = $clog2(ITERS);

    logic             busy;
    logic [CNT_W-1:0] count;
    xlen_t            mcand;
    xlen_t            mplier;
    xlen_t            acc;
    xlen_t            acc_next;

    // low product bits are sign independent, so is_signed and want_rem are not read
    always_comb begin
        acc_next = acc;
        for (int i = 0; i < BITS_PER_CYCLE; i++) begin
            if (mplier[i]) begin
                acc_next = acc_next + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            count     <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (port.abort) begin
                busy <= 1'b0;
            end else if (port.start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CNT_W'(ITERS - 1)) begin
                    busy      <= 1'b0;
                    port.done <= 1'b1;
                end
            end
        end
    end

    // multiplicand walks left, multiplier walks right
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcand  <= '0;
            mplier <= '0;
            acc    <= '0;
        end else if (port.start) begin
            mcand  <= port.a;
            mplier <= port.b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << BITS_PER_CYCLE;
            mplier <= mplier >> BITS_PER_CYCLE;
        end
    end

    assign port.result = acc;

    assert property (@(posedge clk) disable iff (!rst_n)
        port.start |-> !busy);

endmodule

`default_nettype wire

//--- verilog/exu_divider.sv
`default_nettype none

module exu_divider (
    input  logic   clk,
    input  logic   rst_n,
    muldiv_if.unit port
);
    import exu_pkg::*;

    localparam int unsigned CNT_W = $clog2(XLEN);

    logic             busy;
    logic [CNT_W-1:0] count;
    xlen_t            quo;
    xlen_t            rem_acc;
    xlen_t            divisor;
    xlen_t            dividend;
    logic             neg_quo;
    logic             neg_rem;
    logic             div_zero;
    logic             overflow;
    logic             want_rem_q;
    logic             a_neg;
    logic             b_neg;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    xlen_t            quo_next;
    xlen_t            rem_next;
    xlen_t            quo_fix;
    xlen_t            rem_fix;

    assign a_neg = port.is_signed && port.a[XLEN-1];
    assign b_neg = port.is_signed && port.b[XLEN-1];

    // one restoring step, one extra bit since the divisor may use all 64
    always_comb begin
        shifted = {rem_acc, quo[XLEN-1]};
        diff    = shifted - {1'b0, divisor};
        if (!diff[XLEN]) begin
            rem_next = diff[XLEN-1:0];
            quo_next = {quo[XLEN-2:0], 1'b1};
        end else begin
            rem_next = shifted[XLEN-1:0];
            quo_next = {quo[XLEN-2:0], 1'b0};
        end
    end

    // sign fixup, then the RISC-V special cases
    always_comb begin
        quo_fix = neg_quo ? -quo_next : quo_next;
        rem_fix = neg_rem ? -rem_next : rem_next;
        if (div_zero) begin
            quo_fix = '1;
            rem_fix = dividend;
        end else if (overflow) begin
            quo_fix = dividend;
            rem_fix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            count     <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (port.abort) begin
                busy <= 1'b0;
            end else if (port.start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CNT_W'(XLEN - 1)) begin
                    busy      <= 1'b0;
                    port.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quo         <= '0;
            divisor     <= '0;
            rem_acc     <= '0;
            dividend    <= '0;
            neg_quo     <= 1'b0;
            neg_rem     <= 1'b0;
            div_zero    <= 1'b0;
            overflow    <= 1'b0;
            want_rem_q  <= 1'b0;
            port.result <= '0;
        end else if (port.start) begin
            quo        <= a_neg ? -port.a : port.a;
            divisor    <= b_neg ? -port.b : port.b;
            rem_acc    <= '0;
            dividend   <= port.a;
            neg_quo    <= a_neg ^ b_neg;
            neg_rem    <= a_neg;
            div_zero   <= (port.b == '0);
            overflow   <= port.is_signed && (port.a == {1'b1, {(XLEN - 1){1'b0}}}) &&
                          (port.b == '1);
            want_rem_q <= port.want_rem;
        end else if (busy) begin
            quo     <= quo_next;
            rem_acc <= rem_next;
            if (count == CNT_W'(XLEN - 1)) begin
                port.result <= want_rem_q ? rem_fix : quo_fix;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        port.done |-> $past(busy));

endmodule

`default_nettype wire

//--- verilog/exu_top.sv
`default_nettype none

module exu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              issue,
    input  exu_pkg::alu_op_e  operate,
    input  exu_pkg::opa_sel_e sel_a,
    input  exu_pkg::opb_sel_e sel_b,
    input  logic              rs1to32,
    input  exu_pkg::xlen_t    pc,
    input  exu_pkg::xlen_t    rs1,
    input  exu_pkg::xlen_t    rs2,
    input  exu_pkg::xlen_t    csr,
    input  exu_pkg::xlen_t    imm,
    output exu_pkg::xlen_t    res,
    output logic              alu_wait
);

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    exu_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .issue    (issue),
        .operate  (operate),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .res      (res),
        .alu_wait (alu_wait),
        .mul_port (mul_bus.requester),
        .div_port (div_bus.requester)
    );

    exu_multiplier u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (mul_bus.unit)
    );

    exu_divider u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (div_bus.unit)
    );

endmodule

`default_nettype wire

//--- dv/exu_tb.sv
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int NUM_ROWS = 30;
    localparam int ROW_WORDS = 11;
    localparam int NUM_RAND = 8;
    localparam int MUL_WAIT = 33;
    localparam int DIV_WAIT = 65;
    // loop count at which flush or a stray issue is driven during a stall
    localparam int FLUSH_AT = 5;
    localparam int STRAY_AT = 10;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RAND) * 70 + 100;

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     issue;
    alu_op_e  operate;
    opa_sel_e sel_a;
    opb_sel_e sel_b;
    logic     rs1to32;
    xlen_t    pc;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    csr;
    xlen_t    imm;
    xlen_t    res;
    logic     alu_wait;

    // result the DUT must keep while a long op is in flight
    xlen_t    held_res;

    logic [63:0] golden [0:NUM_ROWS*ROW_WORDS-1];

    exu_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .issue    (issue),
        .operate  (operate),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .res      (res),
        .alu_wait (alu_wait)
    );

    always #5 clk = ~clk;

    task automatic check_res(input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: res is %h, expected %h", $time, got, exp);
            $display("Verification failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_wait(input int got, input int exp);
        if (got != exp) begin
            $display("Error at time %0t: alu_wait cycles is %0d, expected %0d", $time, got, exp);
            $display("Verification failed");
            $fatal(1, "stall length mismatch");
        end
    endtask

    // stall length from the timing rules, a flushed op stops one edge after flush
    function automatic int expected_wait(input alu_op_e op, input logic fl);
        int n;
        case (op)
            mul:                  n = MUL_WAIT;
            div, divu, rem, remu: n = DIV_WAIT;
            default:              n = 0;
        endcase
        if (fl && n != 0) begin
            n = FLUSH_AT + 1;
        end
        return n;
    endfunction

    task automatic run_op(input alu_op_e op, input opa_sel_e sa, input opb_sel_e sb,
                          input logic r32, input logic fl, input xlen_t pc_v,
                          input xlen_t rs1_v, input xlen_t rs2_v, input xlen_t csr_v,
                          input xlen_t imm_v, input xlen_t exp_v);
        int cnt;
        @(posedge clk);
        operate <= op;
        sel_a   <= sa;
        sel_b   <= sb;
        rs1to32 <= r32;
        pc      <= pc_v;
        rs1     <= rs1_v;
        rs2     <= rs2_v;
        csr     <= csr_v;
        imm     <= imm_v;
        issue   <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        cnt = 0;
        // count stalled cycles, poke issue or flush while the unit works
        while (alu_wait === 1'b1 && cnt < 200) begin
            // res keeps the previous result for the whole stall
            check_res(res, held_res);
            cnt++;
            @(posedge clk);
            issue <= (cnt == STRAY_AT);
            flush <= fl && (cnt == FLUSH_AT);
            @(negedge clk);
        end
        check_wait(cnt, expected_wait(op, fl));
        check_res(res, exp_v);
        held_res = exp_v;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int    base;
        xlen_t a_v;
        xlen_t b_v;
        xlen_t exp_v;
        alu_op_e op_v;
        void'($urandom(32'h1dd4b97a));
        clk      = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        issue    = 1'b0;
        operate  = add;
        sel_a    = opa_pc;
        sel_b    = opb_imm;
        rs1to32  = 1'b0;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        imm      = '0;
        held_res = '0;
        $readmemh("dv/exu_golden.txt", golden);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_res(res, '0);
        check_wait(int'(alu_wait), 0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            base = i * ROW_WORDS;
            run_op(alu_op_e'(golden[base][4:0]), opa_sel_e'(golden[base+1][1:0]),
                   opb_sel_e'(golden[base+2][1:0]), golden[base+3][0], golden[base+4][0],
                   golden[base+5], golden[base+6], golden[base+7], golden[base+8],
                   golden[base+9], golden[base+10]);
        end

        // random operands, expected values straight from the operation rules
        for (int i = 0; i < NUM_RAND; i++) begin
            a_v = {$urandom, $urandom};
            b_v = {$urandom, $urandom};
            case (i % 4)
                0: begin
                    op_v  = add;
                    exp_v = a_v + b_v;
                end
                1: begin
                    op_v  = xor_op;
                    exp_v = a_v ^ b_v;
                end
                2: begin
                    op_v  = sltu;
                    exp_v = (a_v < b_v) ? xlen_t'(1) : xlen_t'(0);
                end
                default: begin
                    op_v  = mul;
                    exp_v = a_v * b_v;
                end
            endcase
            run_op(op_v, opa_rs1, opb_rs2, 1'b0, 1'b0, '0, a_v, b_v, '0, '0, exp_v);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- exu_top.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/muldiv_if.sv
verilog/exu_alu.sv
verilog/exu_multiplier.sv
verilog/exu_divider.sv
verilog/exu_top.sv
dv/exu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f exu_top.f --top-module exu_tb -o exu_sim &&
{ ./obj_dir/exu_sim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "Verification passed" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- dv/exu_golden.txt
// op sel_a sel_b rs1to32 flush pc rs1 rs2 csr imm expected
// all columns hex, one test per line
00 1 1 0 0 1000 5 7 0 0 c
01 0 0 0 0 2000 1 2 3 10 1ff0
02 2 1 0 0 4000 5 7 0 0 4000
03 1 2 0 0 1000 5 7 deadbeef 0 deadbeef
02 1 1 1 0 1000 ffffffff12345678 7 0 0 12345678
00 1 3 1 0 1000 ffffffff80000000 99 0 1 80000001
04 1 1 0 0 0 ff00ff00 0ff00ff0 0 0 f0f0f0f0
05 1 1 0 0 0 f0 0f 0 0 ff
06 1 1 0 0 0 f0f ff0 0 0 f00
07 1 0 0 0 0 3 0 0 28 30000000000
08 1 1 0 0 0 8000000000000000 3f 0 0 1
09 1 1 0 0 0 8000000000000000 3c 0 0 fffffffffffffff8
09 1 1 1 0 0 ffffffff80000000 44 0 0 f8000000
0a 1 1 0 0 0 ffffffffffffffff 1 0 0 1
0b 1 1 0 0 0 ffffffffffffffff 1 0 0 0
0c 1 2 0 0 0 1234 0 1234 0 1
0d 1 1 0 0 0 ffffffffffffffff 1 0 0 0
0e 1 1 0 0 0 ffffffffffffffff 1 0 0 1
0f 1 1 0 0 0 ffffffff ffffffff 0 0 fffffffe00000001
0f 1 1 0 0 0 ffffffffffffffff 5 0 0 fffffffffffffffb
10 1 1 0 0 0 fffffffffffffff9 2 0 0 fffffffffffffffd
12 1 1 0 0 0 fffffffffffffff9 2 0 0 ffffffffffffffff
11 1 1 0 0 0 64 7 0 0 e
13 1 1 0 0 0 64 7 0 0 2
10 1 1 0 0 0 1234 0 0 0 ffffffffffffffff
13 1 1 0 0 0 1234 0 0 0 1234
10 1 1 0 1 0 64 7 0 0 1234
00 1 1 0 0 0 1 2 0 0 3
10 1 1 0 0 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000
12 1 1 0 0 0 8000000000000000 ffffffffffffffff 0 0 0
